/* Bender.yml */
package:
  name: afu_write_path

sources:
  - common/afu_pkg.sv
  - write_buffer/line_ram.sv
  - write_buffer/write_data_buffer.sv
  - verilog/write_engine.sv
  - verilog/write_arbiter.sv
  - verilog/afu_write_path.sv
  - target: test
    files:
      - tests/afu_write_path_checker.sv
      - tests/afu_write_path_tb.sv

/* common/afu_pkg.sv */
`default_nettype none

package afu_pkg;

  ////////////////////////////////
  // line geometry
  ////////////////////////////////

  // one half cache line as carried on the data bus
  localparam int HALF_LINE_BITS = 512;
  // 64-bit double words per half line
  localparam int DWORDS = HALF_LINE_BITS / 64;
  localparam int TAG_BITS = 8;
  // buffer-read address width from the host
  localparam int ADDR_BITS = 6;

  // which line ram serves a buffer read
  typedef enum logic {
    HALF_LOW,
    HALF_HIGH
  } half_sel_e;

  // round-robin priority holder
  typedef enum logic {
    OWNER_ENGINE0,
    OWNER_ENGINE1
  } arb_owner_e;

  ////////////////////////////////
  // parity helpers
  ////////////////////////////////

  // odd parity, one bit per double word
  function automatic logic [DWORDS-1:0] dword_parity(input logic [HALF_LINE_BITS-1:0] data);
    logic [DWORDS-1:0] par;
    for (int i = 0; i < DWORDS; i++) begin
      par[i] = ~^data[64*i +: 64];
    end
    return par;
  endfunction

  // odd parity over the tag
  function automatic logic tag_parity(input logic [TAG_BITS-1:0] tag);
    return ~^tag;
  endfunction

endpackage

`default_nettype wire

/* flist.f */
common/afu_pkg.sv
write_buffer/line_ram.sv
write_buffer/write_data_buffer.sv
verilog/write_engine.sv
verilog/write_arbiter.sv
verilog/afu_write_path.sv
tests/afu_write_path_checker.sv
tests/afu_write_path_tb.sv

/* tests/afu_write_path_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module afu_write_path_checker (
  input logic clock,
  input logic rstn,
  input logic send,
  input logic room,
  input logic gnt_a,
  input logic gnt_b,
  input logic err
);

  // failure tally for the end of run summary
  int failures = 0;

  ////////////////////////////////
  // credit protocol
  ////////////////////////////////

  // a send needs a free slot, i.e. a credit still held by the source
  send_needs_credit: assert property (
    @(posedge clock) disable iff (!rstn) send |-> room
  ) else begin
    failures++;
    $error("source sent a line while holding no credit");
  end

  // one owner of the buffer write port per cycle
  single_grant: assert property (
    @(posedge clock) disable iff (!rstn) !(gnt_a && gnt_b)
  ) else begin
    failures++;
    $error("both engines granted in the same cycle");
  end

  ////////////////////////////////
  // read side
  ////////////////////////////////

  // tag parity error is a single-cycle pulse
  error_is_pulse: assert property (
    @(posedge clock) disable iff (!rstn) err |=> !err
  ) else begin
    failures++;
    $error("data_write_error held high for more than one cycle");
  end

endmodule

`default_nettype wire

/* tests/afu_write_path_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module afu_write_path_tb;

  localparam int ENGINE_CREDITS = 4;
  localparam int RAM_DEPTH      = 256;
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int HB = afu_pkg::HALF_LINE_BITS;
  localparam int DW = afu_pkg::DWORDS;
  localparam int TW = afu_pkg::TAG_BITS;
  localparam int AW = afu_pkg::ADDR_BITS;

  logic          clock;
  logic          rstn;
  logic          enabled;
  logic          src_valid_0;
  logic [TW-1:0] src_tag_0;
  logic [HB-1:0] src_half0_0;
  logic [HB-1:0] src_half1_0;
  logic          src_credit_0;
  logic          src_valid_1;
  logic [TW-1:0] src_tag_1;
  logic [HB-1:0] src_half0_1;
  logic [HB-1:0] src_half1_1;
  logic          src_credit_1;
  logic          rd_valid;
  logic [TW-1:0] rd_tag;
  logic          rd_tag_par;
  logic [AW-1:0] rd_address;
  logic [HB-1:0] rd_data;
  logic [DW-1:0] rd_parity;
  logic          data_write_error;

  // reference model, both halves per tag
  logic [HB-1:0] model_half0 [RAM_DEPTH];
  logic [HB-1:0] model_half1 [RAM_DEPTH];
  // per source credit bookkeeping
  int spent [2];
  int returned [2];

  int cycles = 0;
  int checks = 0;
  int errors = 0;
  int test_errors = 0;
  int tests = 0;

  afu_write_path #(
    .ENGINE_CREDITS(ENGINE_CREDITS),
    .RAM_DEPTH     (RAM_DEPTH)
  ) u_afu_write_path (
    .clock           (clock),
    .rstn            (rstn),
    .enabled         (enabled),
    .src_valid_0     (src_valid_0),
    .src_tag_0       (src_tag_0),
    .src_half0_0     (src_half0_0),
    .src_half1_0     (src_half1_0),
    .src_credit_0    (src_credit_0),
    .src_valid_1     (src_valid_1),
    .src_tag_1       (src_tag_1),
    .src_half0_1     (src_half0_1),
    .src_half1_1     (src_half1_1),
    .src_credit_1    (src_credit_1),
    .rd_valid        (rd_valid),
    .rd_tag          (rd_tag),
    .rd_tag_par      (rd_tag_par),
    .rd_address      (rd_address),
    .rd_data         (rd_data),
    .rd_parity       (rd_parity),
    .data_write_error(data_write_error)
  );

  ////////////////////////////////
  // protocol checkers
  ////////////////////////////////

  bind write_engine afu_write_path_checker u_protocol_check (
    .clock(clock),
    .rstn (rstn),
    .send (src_valid),
    .room (count < ENGINE_CREDITS),
    .gnt_a(gnt),
    .gnt_b(1'b0),
    .err  (1'b0)
  );

  bind write_arbiter afu_write_path_checker u_protocol_check (
    .clock(clock),
    .rstn (rstn),
    .send (1'b0),
    .room (1'b1),
    .gnt_a(gnt_0),
    .gnt_b(gnt_1),
    .err  (1'b0)
  );

  bind write_data_buffer afu_write_path_checker u_protocol_check (
    .clock(clock),
    .rstn (rstn),
    .send (1'b0),
    .room (1'b1),
    .gnt_a(1'b0),
    .gnt_b(1'b0),
    .err  (data_write_error)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // hard stop well past the length of all tests
  always @(posedge clock) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // credit pulses counted mid-cycle where they are stable
  always @(negedge clock) begin
    if (rstn && src_credit_0) begin
      returned[0]++;
    end
    if (rstn && src_credit_1) begin
      returned[1]++;
    end
  end

  ////////////////////////////////
  // expected values
  ////////////////////////////////

  // odd parity bit is set when a double word has an even number of ones
  function automatic logic [DW-1:0] expect_dword_parity(input logic [HB-1:0] data);
    logic [DW-1:0] par;
    for (int i = 0; i < DW; i++) begin
      par[i] = ($countones(data[64*i +: 64]) % 2) == 0;
    end
    return par;
  endfunction

  function automatic logic expect_tag_parity(input logic [TW-1:0] tag);
    return ($countones(tag) % 2) == 0;
  endfunction

  function automatic logic [HB-1:0] random_half();
    logic [HB-1:0] h;
    for (int i = 0; i < HB / 32; i++) begin
      h[32*i +: 32] = $urandom();
    end
    return h;
  endfunction

  function automatic int credits_held(input int eng);
    return ENGINE_CREDITS - spent[eng] + returned[eng];
  endfunction

  function automatic int checker_failures();
    return u_afu_write_path.u_engine0.u_protocol_check.failures
         + u_afu_write_path.u_engine1.u_protocol_check.failures
         + u_afu_write_path.u_arbiter.u_protocol_check.failures
         + u_afu_write_path.u_buffer.u_protocol_check.failures;
  endfunction

  ////////////////////////////////
  // compare tasks
  ////////////////////////////////

  task automatic check_line(input string name, input logic [HB-1:0] exp,
                            input logic [HB-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_parity(input string name, input logic [DW-1:0] exp,
                              input logic [DW-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("error: %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_credits(input string name);
    for (int eng = 0; eng < 2; eng++) begin
      checks++;
      if (credits_held(eng) != ENGINE_CREDITS) begin
        errors++;
        test_errors++;
        $display("error: %s source %0d credits returned expected %0d actual %0d", name,
                 eng, spent[eng], returned[eng]);
      end
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %s: %s", name, (test_errors == 0) ? "passed" : "failed");
    test_errors = 0;
  endtask

  ////////////////////////////////
  // drivers
  ////////////////////////////////

  task automatic drive_source(input int eng, input logic valid, input logic [TW-1:0] tag,
                              input logic [HB-1:0] h0, input logic [HB-1:0] h1);
    if (eng == 0) begin
      src_valid_0 = valid;
      src_tag_0   = tag;
      src_half0_0 = h0;
      src_half1_0 = h1;
    end else begin
      src_valid_1 = valid;
      src_tag_1   = tag;
      src_half0_1 = h0;
      src_half1_1 = h1;
    end
  endtask

  task automatic idle_source(input int eng);
    if (eng == 0) begin
      src_valid_0 = 1'b0;
    end else begin
      src_valid_1 = 1'b0;
    end
  endtask

  // one line from a source, stalling while no credit is held
  task automatic send_line(input int eng, input logic [TW-1:0] tag);
    logic [HB-1:0] h0;
    logic [HB-1:0] h1;
    h0 = random_half();
    h1 = random_half();
    if (credits_held(eng) == 0) begin
      idle_source(eng);
      while (credits_held(eng) == 0) begin
        @(posedge clock);
        #2;
      end
    end
    drive_source(eng, 1'b1, tag, h0, h1);
    spent[eng]++;
    model_half0[tag] = h0;
    model_half1[tag] = h1;
    @(posedge clock);
    #2;
  endtask

  task automatic send_burst(input int eng, input logic [TW-1:0] base, input int n);
    for (int i = 0; i < n; i++) begin
      send_line(eng, base + TW'(i));
    end
    idle_source(eng);
  endtask

  // a returned credit means the line is readable one cycle later
  task automatic wait_credits();
    while (returned[0] < spent[0] || returned[1] < spent[1]) begin
      @(posedge clock);
      #2;
    end
  endtask

  task automatic read_half(input logic [TW-1:0] tag, input logic [AW-1:0] addr,
                           input logic par, output logic [HB-1:0] data,
                           output logic [DW-1:0] par_out);
    rd_valid   = 1'b1;
    rd_tag     = tag;
    rd_tag_par = par;
    rd_address = addr;
    @(posedge clock);
    #2;
    rd_valid = 1'b0;
    // data valid in the cycle after the request edge
    @(negedge clock);
    data    = rd_data;
    par_out = rd_parity;
    @(posedge clock);
    #2;
  endtask

  task automatic check_tag(input string name, input logic [TW-1:0] tag,
                           input logic [AW-1:0] high_addr);
    logic [HB-1:0] data;
    logic [DW-1:0] par;
    read_half(tag, '0, expect_tag_parity(tag), data, par);
    check_line({name, " half0"}, model_half0[tag], data);
    check_parity({name, " half0 parity"}, expect_dword_parity(model_half0[tag]), par);
    read_half(tag, high_addr, expect_tag_parity(tag), data, par);
    check_line({name, " half1"}, model_half1[tag], data);
    check_parity({name, " half1 parity"}, expect_dword_parity(model_half1[tag]), par);
  endtask

  ////////////////////////////////
  // directed tests
  ////////////////////////////////

  task automatic test_single_write();
    send_line(0, 8'h05);
    idle_source(0);
    wait_credits();
    check_tag("single_write", 8'h05, 6'd1);
    // any nonzero address picks the high half
    check_tag("single_write addr 3f", 8'h05, 6'h3f);
    check_credits("single_write");
    finish_test("single_write");
  endtask

  task automatic test_contention();
    fork
      send_burst(0, 8'h10, 2 * ENGINE_CREDITS);
      send_burst(1, 8'h20, 2 * ENGINE_CREDITS);
    join
    wait_credits();
    check_credits("contention");
    for (int i = 0; i < 2 * ENGINE_CREDITS; i++) begin
      check_tag($sformatf("contention tag %02h", 8'h10 + i), 8'h10 + TW'(i), 6'd1);
      check_tag($sformatf("contention tag %02h", 8'h20 + i), 8'h20 + TW'(i), 6'd1);
    end
    finish_test("contention");
  endtask

  task automatic test_disabled_read();
    logic [HB-1:0] data;
    logic [DW-1:0] par;
    enabled = 1'b0;
    // bad tag parity too, still no error while disabled
    read_half(8'h05, '0, ~expect_tag_parity(8'h05), data, par);
    check_line("disabled_read data", '1, data);
    check_parity("disabled_read parity", expect_dword_parity('1), par);
    repeat (4) begin
      @(negedge clock);
      check_flag("disabled_read error", 1'b0, data_write_error);
    end
    @(posedge clock);
    #2;
    enabled = 1'b1;
    finish_test("disabled_read");
  endtask

  // error must show exactly three cycles after the request edge
  task automatic watch_error(input string name, input logic [TW-1:0] tag, input logic bad);
    rd_valid   = 1'b1;
    rd_tag     = tag;
    rd_tag_par = expect_tag_parity(tag) ^ bad;
    rd_address = '0;
    @(posedge clock);
    #2;
    rd_valid = 1'b0;
    for (int k = 0; k < 5; k++) begin
      @(negedge clock);
      check_flag($sformatf("%s cycle %0d", name, k), bad && (k == 3), data_write_error);
    end
    @(posedge clock);
    #2;
  endtask

  task automatic test_tag_parity_error();
    watch_error("tag_parity bad", 8'h05, 1'b1);
    watch_error("tag_parity good", 8'h05, 1'b0);
    watch_error("tag_parity bad other tag", 8'h2b, 1'b1);
    finish_test("tag_parity_error");
  endtask

  task automatic test_overwrite();
    send_line(1, 8'h05);
    idle_source(1);
    wait_credits();
    check_tag("overwrite", 8'h05, 6'd1);
    check_credits("overwrite");
    finish_test("overwrite");
  endtask

  initial begin
    void'($urandom(32'h80db));
    rstn        = 1'b0;
    enabled     = 1'b1;
    rd_valid    = 1'b0;
    rd_tag      = '0;
    rd_tag_par  = 1'b0;
    rd_address  = '0;
    drive_source(0, 1'b0, '0, '0, '0);
    drive_source(1, 1'b0, '0, '0, '0);
    spent[0]    = 0;
    spent[1]    = 0;
    returned[0] = 0;
    returned[1] = 0;
    repeat (10) @(posedge clock);
    #2;
    rstn = 1'b1;
    @(posedge clock);
    #2;

    test_single_write();
    test_contention();
    test_disabled_read();
    test_tag_parity_error();
    test_overwrite();

    errors += checker_failures();
    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d", tests, checks,
             errors, checker_failures());
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/afu_write_path.sv */
`timescale 1ns/1ns
`default_nettype none

module afu_write_path #(
  parameter int ENGINE_CREDITS = 4,
  parameter int RAM_DEPTH      = 256
) (
  input  logic                                clock,
  input  logic                                rstn,
  input  logic                                enabled,
  input  logic                                src_valid_0,
  input  logic [afu_pkg::TAG_BITS-1:0]        src_tag_0,
  input  logic [afu_pkg::HALF_LINE_BITS-1:0]  src_half0_0,
  input  logic [afu_pkg::HALF_LINE_BITS-1:0]  src_half1_0,
  output logic                                src_credit_0,
  input  logic                                src_valid_1,
  input  logic [afu_pkg::TAG_BITS-1:0]        src_tag_1,
  input  logic [afu_pkg::HALF_LINE_BITS-1:0]  src_half0_1,
  input  logic [afu_pkg::HALF_LINE_BITS-1:0]  src_half1_1,
  output logic                                src_credit_1,
  input  logic                                rd_valid,
  input  logic [afu_pkg::TAG_BITS-1:0]        rd_tag,
  input  logic                                rd_tag_par,
  input  logic [afu_pkg::ADDR_BITS-1:0]       rd_address,
  output logic [afu_pkg::HALF_LINE_BITS-1:0]  rd_data,
  output logic [afu_pkg::DWORDS-1:0]          rd_parity,
  output logic                                data_write_error
);

  // engine heads toward the arbiter
  logic                               req_0;
  logic                               req_1;
  logic                               gnt_0;
  logic                               gnt_1;
  logic [afu_pkg::TAG_BITS-1:0]       head_tag_0;
  logic [afu_pkg::TAG_BITS-1:0]       head_tag_1;
  logic [afu_pkg::HALF_LINE_BITS-1:0] head_half0_0;
  logic [afu_pkg::HALF_LINE_BITS-1:0] head_half1_0;
  logic [afu_pkg::HALF_LINE_BITS-1:0] head_half0_1;
  logic [afu_pkg::HALF_LINE_BITS-1:0] head_half1_1;

  // shared buffer write port
  logic                               buf_wr_valid;
  logic [afu_pkg::TAG_BITS-1:0]       buf_wr_tag;
  logic [afu_pkg::HALF_LINE_BITS-1:0] buf_wr_half0;
  logic [afu_pkg::HALF_LINE_BITS-1:0] buf_wr_half1;

  ////////////////////////////////
  // write engines
  ////////////////////////////////

  write_engine #(
    .ENGINE_CREDITS(ENGINE_CREDITS)
  ) u_engine0 (
    .clock     (clock),
    .rstn      (rstn),
    .src_valid (src_valid_0),
    .src_tag   (src_tag_0),
    .src_half0 (src_half0_0),
    .src_half1 (src_half1_0),
    .src_credit(src_credit_0),
    .req       (req_0),
    .head_tag  (head_tag_0),
    .head_half0(head_half0_0),
    .head_half1(head_half1_0),
    .gnt       (gnt_0)
  );

  write_engine #(
    .ENGINE_CREDITS(ENGINE_CREDITS)
  ) u_engine1 (
    .clock     (clock),
    .rstn      (rstn),
    .src_valid (src_valid_1),
    .src_tag   (src_tag_1),
    .src_half0 (src_half0_1),
    .src_half1 (src_half1_1),
    .src_credit(src_credit_1),
    .req       (req_1),
    .head_tag  (head_tag_1),
    .head_half0(head_half0_1),
    .head_half1(head_half1_1),
    .gnt       (gnt_1)
  );

  ////////////////////////////////
  // arbiter and buffer
  ////////////////////////////////

  write_arbiter u_arbiter (
    .clock       (clock),
    .rstn        (rstn),
    .req_0       (req_0),
    .head_tag_0  (head_tag_0),
    .head_half0_0(head_half0_0),
    .head_half1_0(head_half1_0),
    .req_1       (req_1),
    .head_tag_1  (head_tag_1),
    .head_half0_1(head_half0_1),
    .head_half1_1(head_half1_1),
    .gnt_0       (gnt_0),
    .gnt_1       (gnt_1),
    .buf_wr_valid(buf_wr_valid),
    .buf_wr_tag  (buf_wr_tag),
    .buf_wr_half0(buf_wr_half0),
    .buf_wr_half1(buf_wr_half1)
  );

  write_data_buffer #(
    .RAM_DEPTH(RAM_DEPTH)
  ) u_buffer (
    .clock           (clock),
    .rstn            (rstn),
    .enabled         (enabled),
    .buf_wr_valid    (buf_wr_valid),
    .buf_wr_tag      (buf_wr_tag),
    .buf_wr_half0    (buf_wr_half0),
    .buf_wr_half1    (buf_wr_half1),
    .rd_valid        (rd_valid),
    .rd_tag          (rd_tag),
    .rd_tag_par      (rd_tag_par),
    .rd_address      (rd_address),
    .rd_data         (rd_data),
    .rd_parity       (rd_parity),
    .data_write_error(data_write_error)
  );

endmodule

`default_nettype wire

/* verilog/write_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module write_arbiter (
  input  logic                                clock,
  input  logic                                rstn,
  input  logic                                req_0,
  input  logic [afu_pkg::TAG_BITS-1:0]        head_tag_0,
  input  logic [afu_pkg::HALF_LINE_BITS-1:0]  head_half0_0,
  input  logic [afu_pkg::HALF_LINE_BITS-1:0]  head_half1_0,
  input  logic                                req_1,
  input  logic [afu_pkg::TAG_BITS-1:0]        head_tag_1,
  input  logic [afu_pkg::HALF_LINE_BITS-1:0]  head_half0_1,
  input  logic [afu_pkg::HALF_LINE_BITS-1:0]  head_half1_1,
  output logic                                gnt_0,
  output logic                                gnt_1,
  output logic                                buf_wr_valid,
  output logic [afu_pkg::TAG_BITS-1:0]        buf_wr_tag,
  output logic [afu_pkg::HALF_LINE_BITS-1:0]  buf_wr_half0,
  output logic [afu_pkg::HALF_LINE_BITS-1:0]  buf_wr_half1
);

  afu_pkg::arb_owner_e owner;
  logic                contested;

  assign contested = req_0 & req_1;

  // lone requester always wins, owner breaks ties
  assign gnt_0 = req_0 & (!req_1 || owner == afu_pkg::OWNER_ENGINE0);
  assign gnt_1 = req_1 & (!req_0 || owner == afu_pkg::OWNER_ENGINE1);

  ////////////////////////////////
  // shared write port mux
  ////////////////////////////////

  assign buf_wr_valid = gnt_0 | gnt_1;
  assign buf_wr_tag   = gnt_1 ? head_tag_1   : head_tag_0;
  assign buf_wr_half0 = gnt_1 ? head_half0_1 : head_half0_0;
  assign buf_wr_half1 = gnt_1 ? head_half1_1 : head_half1_0;

  // priority passes to the loser after a tie
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      owner <= afu_pkg::OWNER_ENGINE0;
    end else if (contested) begin
      owner <= gnt_0 ? afu_pkg::OWNER_ENGINE1 : afu_pkg::OWNER_ENGINE0;
    end
  end

endmodule

`default_nettype wire

/* verilog/write_engine.sv */
`timescale 1ns/1ns
`default_nettype none

module write_engine #(
  parameter int ENGINE_CREDITS = 4
) (
  input  logic                                clock,
  input  logic                                rstn,
  input  logic                                src_valid,
  input  logic [afu_pkg::TAG_BITS-1:0]        src_tag,
  input  logic [afu_pkg::HALF_LINE_BITS-1:0]  src_half0,
  input  logic [afu_pkg::HALF_LINE_BITS-1:0]  src_half1,
  output logic                                src_credit,
  output logic                                req,
  output logic [afu_pkg::TAG_BITS-1:0]        head_tag,
  output logic [afu_pkg::HALF_LINE_BITS-1:0]  head_half0,
  output logic [afu_pkg::HALF_LINE_BITS-1:0]  head_half1,
  input  logic                                gnt
);

  // pointer and count widths, at least one bit
  localparam int PTR_BITS = (ENGINE_CREDITS > 1) ? $clog2(ENGINE_CREDITS) : 1;
  localparam int CNT_BITS = $clog2(ENGINE_CREDITS + 1);
  localparam logic [PTR_BITS-1:0] LAST_PTR = PTR_BITS'(ENGINE_CREDITS - 1);

  // queue storage, one slot per credit
  logic [afu_pkg::TAG_BITS-1:0]       tag_mem   [ENGINE_CREDITS];
  logic [afu_pkg::HALF_LINE_BITS-1:0] half0_mem [ENGINE_CREDITS];
  logic [afu_pkg::HALF_LINE_BITS-1:0] half1_mem [ENGINE_CREDITS];

  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                pop;

  // grant only arrives while requesting
  assign pop = gnt & req;
  assign req = (count != '0);

  // head of queue straight to the arbiter
  assign head_tag   = tag_mem[rd_ptr];
  assign head_half0 = half0_mem[rd_ptr];
  assign head_half1 = half1_mem[rd_ptr];

  ////////////////////////////////
  // push side
  ////////////////////////////////

  // source holds a credit, so no full check
  always_ff @(posedge clock) begin
    if (src_valid) begin
      tag_mem[wr_ptr]   <= src_tag;
      half0_mem[wr_ptr] <= src_half0;
      half1_mem[wr_ptr] <= src_half1;
    end
  end

  ////////////////////////////////
  // pointers, count, credit
  ////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      src_credit <= 1'b0;
    end else begin
      if (src_valid) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves count alone
      if (src_valid && !pop) begin
        count <= count + 1'b1;
      end else if (!src_valid && pop) begin
        count <= count - 1'b1;
      end
      // credit goes back the cycle after the pop
      src_credit <= pop;
    end
  end

endmodule

`default_nettype wire

/* write_buffer/line_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module line_ram #(
  parameter int WIDTH = afu_pkg::HALF_LINE_BITS,
  parameter int DEPTH = 256
) (
  input  logic                          clock,
  input  logic                          we,
  input  logic [afu_pkg::TAG_BITS-1:0]  wr_addr,
  input  logic [WIDTH-1:0]              data_in,
  input  logic [afu_pkg::TAG_BITS-1:0]  rd_addr,
  output logic [WIDTH-1:0]              data_out
);

  // one half line per tag
  logic [WIDTH-1:0] mem [DEPTH];

  // same-address read returns the old word
  always_ff @(posedge clock) begin
    if (we) begin
      mem[wr_addr] <= data_in;
    end
    data_out <= mem[rd_addr];
  end

endmodule

`default_nettype wire

/* write_buffer/write_data_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module write_data_buffer #(
  parameter int RAM_DEPTH = 256
) (
  input  logic                                clock,
  input  logic                                rstn,
  input  logic                                enabled,
  input  logic                                buf_wr_valid,
  input  logic [afu_pkg::TAG_BITS-1:0]        buf_wr_tag,
  input  logic [afu_pkg::HALF_LINE_BITS-1:0]  buf_wr_half0,
  input  logic [afu_pkg::HALF_LINE_BITS-1:0]  buf_wr_half1,
  input  logic                                rd_valid,
  input  logic [afu_pkg::TAG_BITS-1:0]        rd_tag,
  input  logic                                rd_tag_par,
  input  logic [afu_pkg::ADDR_BITS-1:0]       rd_address,
  output logic [afu_pkg::HALF_LINE_BITS-1:0]  rd_data,
  output logic [afu_pkg::DWORDS-1:0]          rd_parity,
  output logic                                data_write_error
);

  // latched write port
  logic                               wr_valid_q;
  logic [afu_pkg::TAG_BITS-1:0]       wr_tag_q;
  logic [afu_pkg::HALF_LINE_BITS-1:0] wr_half0_q;
  logic [afu_pkg::HALF_LINE_BITS-1:0] wr_half1_q;

  // accepted read request
  logic                               rd_accept;
  logic                               rd_valid_q;
  logic [afu_pkg::TAG_BITS-1:0]       rd_tag_q;
  logic                               rd_tag_par_q;
  afu_pkg::half_sel_e                 rd_half_q;

  logic [afu_pkg::HALF_LINE_BITS-1:0] ram0_out;
  logic [afu_pkg::HALF_LINE_BITS-1:0] ram1_out;

  // error pipe
  logic tag_err_q;
  logic tag_err_d2_q;

  ////////////////////////////////
  // write latch
  ////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wr_valid_q <= 1'b0;
    end else begin
      wr_valid_q <= buf_wr_valid;
    end
  end

  always_ff @(posedge clock) begin
    wr_tag_q   <= buf_wr_tag;
    wr_half0_q <= buf_wr_half0;
    wr_half1_q <= buf_wr_half1;
  end

  ////////////////////////////////
  // read request
  ////////////////////////////////

  assign rd_accept = rd_valid & enabled;

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      rd_valid_q <= 1'b0;
      rd_half_q  <= afu_pkg::HALF_LOW;
    end else begin
      rd_valid_q <= rd_accept;
      // address zero is the low half
      rd_half_q  <= (rd_address == '0) ? afu_pkg::HALF_LOW : afu_pkg::HALF_HIGH;
    end
  end

  always_ff @(posedge clock) begin
    rd_tag_q     <= rd_tag;
    rd_tag_par_q <= rd_tag_par;
  end

  ////////////////////////////////
  // line rams, one per half
  ////////////////////////////////

  line_ram #(
    .WIDTH(afu_pkg::HALF_LINE_BITS),
    .DEPTH(RAM_DEPTH)
  ) u_ram_half0 (
    .clock   (clock),
    .we      (wr_valid_q),
    .wr_addr (wr_tag_q),
    .data_in (wr_half0_q),
    .rd_addr (rd_tag),
    .data_out(ram0_out)
  );

  line_ram #(
    .WIDTH(afu_pkg::HALF_LINE_BITS),
    .DEPTH(RAM_DEPTH)
  ) u_ram_half1 (
    .clock   (clock),
    .we      (wr_valid_q),
    .wr_addr (wr_tag_q),
    .data_in (wr_half1_q),
    .rd_addr (rd_tag),
    .data_out(ram1_out)
  );

  // idle bus reads as all ones
  always_comb begin
    if (!rd_valid_q) begin
      rd_data = '1;
    end else if (rd_half_q == afu_pkg::HALF_LOW) begin
      rd_data = ram0_out;
    end else begin
      rd_data = ram1_out;
    end
  end

  assign rd_parity = afu_pkg::dword_parity(rd_data);

  ////////////////////////////////
  // tag parity error
  ////////////////////////////////

  // compare, then two more flops to the pin
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      tag_err_q        <= 1'b0;
      tag_err_d2_q     <= 1'b0;
      data_write_error <= 1'b0;
    end else begin
      tag_err_q        <= rd_valid_q & (afu_pkg::tag_parity(rd_tag_q) != rd_tag_par_q);
      tag_err_d2_q     <= tag_err_q;
      data_write_error <= tag_err_d2_q;
    end
  end

endmodule

`default_nettype wire
